//--- ex_pipe.f
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_operand_sel.sv
rtl/ex_alu.sv
rtl/ex_brcond.sv
rtl/ex_result_merge.sv
rtl/ex_top.sv
verif/ex_assert.sv
verif/ex_tb.sv

//--- Makefile
# execute stage simulation with Verilator

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= ex_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "sim: pass" || \
		(echo "sim: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/ex_tb.sv
/* execute stage testbench */

`timescale 1ns/10ps

module ex_tb;

  localparam int RESET_CYCLES = 10;
  localparam int ALU_PER_FUNC = 24;   // packets per function code
  localparam int OPSEL_N      = 200;
  localparam int BRANCH_N     = 240;
  localparam int STALL_N      = 60;   // bursts, up to 7 cycles each
  localparam int PASS_N       = 200;
  // random stalls can double the cycles of a packet
  localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + 7 * STALL_N +
                                2 * (17 * ALU_PER_FUNC + OPSEL_N + BRANCH_N + PASS_N);

  logic                   clock;
  logic                   rst_n;
  logic                   stall;
  ex_pkg::id_ex_packet_t  id_ex_in;
  ex_pkg::ex_mem_packet_t ex_mem_out;

  ex_pkg::ex_mem_packet_t exp_out;     // model of the ex/mem register
  ex_pkg::ex_mem_packet_t held_out;    // output seen before a stalled edge
  logic                   held_check;
  ex_pkg::id_ex_packet_t  pkt;
  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int i;
  int k;

  ex_top dut_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .stall      (stall),
    .id_ex_in   (id_ex_in),
    .ex_mem_out (ex_mem_out)
  );

  always #20 clock = ~clock;  // 40 ns period

  // watchdog
  initial begin
    #(TOTAL_CYCLES * 40 * 2);
    $display("timeout: tests still running after %0d cycles", TOTAL_CYCLES * 2);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  // sign extend the low bits of v
  function automatic ex_pkg::word_t sext(input ex_pkg::word_t v, input int bits);
    ex_pkg::word_t s;
    s = v << (64 - bits);
    return ex_pkg::word_t'($signed(s) >>> (64 - bits));
  endfunction

  function automatic ex_pkg::word_t alu_ref(input ex_pkg::alu_func_e f,
                                            input ex_pkg::word_t a, input ex_pkg::word_t b);
    int sh;
    sh = int'(b[5:0]);  // 6-bit shift count
    case (f)
      ex_pkg::ALU_ADDQ:   return a + b;
      ex_pkg::ALU_SUBQ:   return a - b;
      ex_pkg::ALU_AND:    return a & b;
      ex_pkg::ALU_BIC:    return a & ~b;
      ex_pkg::ALU_BIS:    return a | b;
      ex_pkg::ALU_ORNOT:  return a | ~b;
      ex_pkg::ALU_XOR:    return a ^ b;
      ex_pkg::ALU_EQV:    return ~(a ^ b);
      ex_pkg::ALU_SRL:    return a >> sh;
      ex_pkg::ALU_SLL:    return a << sh;
      ex_pkg::ALU_SRA:    return (a >> sh) | (a[63] ? ~(~64'd0 >> sh) : 64'd0);
      ex_pkg::ALU_MULQ:   return a * b;
      ex_pkg::ALU_CMPULT: return {63'd0, a < b};
      ex_pkg::ALU_CMPEQ:  return {63'd0, a == b};
      ex_pkg::ALU_CMPULE: return {63'd0, a <= b};
      ex_pkg::ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      ex_pkg::ALU_CMPLE:  return {63'd0, $signed(a) <= $signed(b)};
      default:            return '0;
    endcase
  endfunction

  function automatic logic cond_ref(input ex_pkg::word_t a, input logic [2:0] f);
    logic t;
    case (f[1:0])
      2'd0:    t = !a[0];             // blbc
      2'd1:    t = (a == '0);
      2'd2:    t = a[63];             // negative
      default: t = a[63] || (a == '0);
    endcase
    return f[2] ? !t : t;  // inverted tests
  endfunction

  function automatic ex_pkg::ex_mem_packet_t model(input ex_pkg::id_ex_packet_t p);
    ex_pkg::ex_mem_packet_t e;
    ex_pkg::word_t          a;
    ex_pkg::word_t          b;
    logic                   bad;
    bad = 1'b0;
    case (p.opa_select)
      ex_pkg::REGA:     a = p.rega_value;
      ex_pkg::MEM_DISP: a = sext(64'(p.inst[15:0]), 16);
      ex_pkg::NPC:      a = p.npc;
      default:          a = 64'hffff_ffff_ffff_fffc;
    endcase
    case (p.opb_select)
      ex_pkg::REGB:    b = p.regb_value;
      ex_pkg::ALU_IMM: b = 64'(p.inst[20:13]);
      ex_pkg::BR_DISP: b = sext(64'(p.inst[20:0]), 21) << 2;
      default: begin
        b   = '0;
        bad = 1'b1;
      end
    endcase
    e              = '0;
    e.alu_result   = alu_ref(p.alu_func, a, b);
    e.npc          = p.npc;
    e.inst         = p.inst;
    e.rega_value   = p.rega_value;
    e.dest_reg_idx = p.dest_reg_idx;
    e.take_branch  = p.valid && (p.uncond_branch ||
                     (p.cond_branch && cond_ref(p.rega_value, p.inst[28:26])));
    e.rd_mem       = p.rd_mem && p.valid;
    e.wr_mem       = p.wr_mem && p.valid;
    e.halt         = p.halt;
    e.illegal      = p.illegal || bad;
    e.valid        = p.valid;
    return e;
  endfunction

  ////////////////////////////////
  // stimulus
  ////////////////////////////////

  // edge values mixed into random words
  function automatic ex_pkg::word_t pick_word();
    case ($urandom_range(5))
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, 63'd0};
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic ex_pkg::id_ex_packet_t random_packet();
    ex_pkg::id_ex_packet_t p;
    p.npc           = {$urandom, $urandom};
    p.inst          = $urandom;
    p.rega_value    = pick_word();
    p.regb_value    = pick_word();
    p.opa_select    = ex_pkg::opa_sel_e'(2'($urandom_range(3)));
    p.opb_select    = ex_pkg::opb_sel_e'(2'($urandom_range(2)));  // legal codes
    p.alu_func      = ex_pkg::alu_func_e'(5'($urandom_range(16)));
    p.dest_reg_idx  = 5'($urandom);
    p.rd_mem        = 1'($urandom);
    p.wr_mem        = 1'($urandom);
    p.cond_branch   = 1'($urandom);
    p.uncond_branch = 1'($urandom);
    p.halt          = ($urandom_range(15) == 0);
    p.illegal       = ($urandom_range(15) == 0);
    p.valid         = ($urandom_range(3) != 0);  // one bubble in four
    return p;
  endfunction

  task automatic compare_field(input string name, input ex_pkg::word_t e, input ex_pkg::word_t a);
    checks++;
    if (a !== e) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h actual %h", $time, name, e, a);
    end
  endtask

  task automatic check_output();
    compare_field("ex_mem_out.alu_result", exp_out.alu_result, ex_mem_out.alu_result);
    compare_field("ex_mem_out.npc", exp_out.npc, ex_mem_out.npc);
    compare_field("ex_mem_out.inst", 64'(exp_out.inst), 64'(ex_mem_out.inst));
    compare_field("ex_mem_out.rega_value", exp_out.rega_value, ex_mem_out.rega_value);
    compare_field("ex_mem_out.dest_reg_idx", 64'(exp_out.dest_reg_idx),
                  64'(ex_mem_out.dest_reg_idx));
    compare_field("ex_mem_out.take_branch", 64'(exp_out.take_branch),
                  64'(ex_mem_out.take_branch));
    compare_field("ex_mem_out.rd_mem", 64'(exp_out.rd_mem), 64'(ex_mem_out.rd_mem));
    compare_field("ex_mem_out.wr_mem", 64'(exp_out.wr_mem), 64'(ex_mem_out.wr_mem));
    compare_field("ex_mem_out.halt", 64'(exp_out.halt), 64'(ex_mem_out.halt));
    compare_field("ex_mem_out.illegal", 64'(exp_out.illegal), 64'(ex_mem_out.illegal));
    compare_field("ex_mem_out.valid", 64'(exp_out.valid), 64'(ex_mem_out.valid));
    if (held_check) begin  // last edge was stalled
      checks++;
      if (ex_mem_out !== held_out) begin
        errors++;
        $display("** Error at %0t ns: ex_mem_out held across stall, expected %h actual %h",
                 $time, held_out, ex_mem_out);
      end
    end
  endtask

  task automatic check_reset_flags();
    compare_field("ex_mem_out.valid", '0, 64'(ex_mem_out.valid));
    compare_field("ex_mem_out.take_branch", '0, 64'(ex_mem_out.take_branch));
    compare_field("ex_mem_out.rd_mem", '0, 64'(ex_mem_out.rd_mem));
    compare_field("ex_mem_out.wr_mem", '0, 64'(ex_mem_out.wr_mem));
    compare_field("ex_mem_out.halt", '0, 64'(ex_mem_out.halt));
  endtask

  // check on the falling edge, drive, then follow the rising edge
  task automatic drive_cycle(input ex_pkg::id_ex_packet_t p, input logic stl);
    @(negedge clock);
    check_output();
    held_out   = ex_mem_out;
    held_check = stl;
    id_ex_in   = p;
    stall      = stl;
    @(posedge clock);
    if (!stl) exp_out = model(p);  // register loads only without stall
  endtask

  // upstream holds p until an edge with stall low takes it
  task automatic send(input ex_pkg::id_ex_packet_t p);
    logic stl;
    do begin
      stl = ($urandom_range(3) == 0);
      drive_cycle(p, stl);
    end while (stl);
  endtask

  task automatic send_burst(input ex_pkg::id_ex_packet_t p, input int len);
    repeat (len) drive_cycle(p, 1'b1);
    drive_cycle(p, 1'b0);
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
    if (errors == test_errors) tests_passed++;
    else tests_failed++;
    test_checks = checks;
    test_errors = errors;
  endtask

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin
    clock = 1'b0;
    rst_n = 1'b0;
    stall = 1'b0;
    id_ex_in = '0;
    exp_out = '0;
    held_out = '0;
    held_check = 1'b0;
    checks = 0;
    errors = 0;
    test_checks = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'h910b));

    repeat (RESET_CYCLES) begin
      @(negedge clock);
      check_reset_flags();
    end
    rst_n = 1'b1;
    drive_cycle('0, 1'b0);  // first edge after reset loads an all-zero packet
    finish_test("reset");

    for (k = 0; k < 17; k++) begin
      for (i = 0; i < ALU_PER_FUNC; i++) begin
        pkt = random_packet();
        pkt.opa_select = ex_pkg::REGA;
        pkt.opb_select = ex_pkg::REGB;
        pkt.alu_func   = ex_pkg::alu_func_e'(5'(k));
        if (i % 3 == 0) pkt.regb_value[5:0] = 6'd0;   // shift by 0
        if (i % 3 == 1) pkt.regb_value[5:0] = 6'd63;  // shift by 63
        send(pkt);
      end
    end
    finish_test("alu_funcs");

    for (i = 0; i < OPSEL_N; i++) begin
      pkt = random_packet();
      pkt.alu_func = ($urandom_range(1) == 0) ? ex_pkg::ALU_ADDQ : ex_pkg::ALU_BIS;
      if ($urandom_range(7) == 0) pkt.opb_select = ex_pkg::opb_sel_e'(2'd3);  // illegal
      send(pkt);
    end
    finish_test("operand_sel");

    for (i = 0; i < BRANCH_N; i++) begin
      pkt = random_packet();
      k = int'($urandom_range(3));
      if (k == 0) pkt.rega_value = '0;
      else if (k == 1) pkt.rega_value[63] = 1'b1;
      pkt.inst[28:26] = 3'(i);  // all eight tests in turn
      send(pkt);
    end
    finish_test("branch_cond");

    for (i = 0; i < STALL_N; i++) begin
      pkt = random_packet();
      send_burst(pkt, int'($urandom_range(6, 1)));
    end
    finish_test("stall");

    for (i = 0; i < PASS_N; i++) begin
      pkt = random_packet();
      send(pkt);
    end
    @(negedge clock);
    check_output();  // last accepted packet
    finish_test("pass_through");

    $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verif/ex_assert.sv
/* execute stage assertions */

`timescale 1ns/10ps

module ex_assert (
  input logic                   clock,
  input logic                   rst_n,
  input logic                   stall,
  input ex_pkg::ex_mem_packet_t ex_mem_out
);

  ////////////////////////////////
  // reset and stall
  ////////////////////////////////

  // register cleared, no valid packet while reset is held
  valid_in_reset: assert property (@(posedge clock) !rst_n |-> !ex_mem_out.valid)
    else $error("ex_mem_out.valid high during reset");

  // back-pressure freezes the ex/mem register for one edge
  stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
    stall |=> $stable(ex_mem_out))
    else $error("ex_mem_out changed across a stalled edge");

  ////////////////////////////////
  // output sanity
  ////////////////////////////////

  // a bubble never redirects fetch
  branch_needs_valid: assert property (@(posedge clock) disable iff (!rst_n)
    ex_mem_out.take_branch |-> ex_mem_out.valid)
    else $error("take_branch high with valid low");

endmodule

bind ex_top ex_assert assert_i (
  .clock      (clock),
  .rst_n      (rst_n),
  .stall      (stall),
  .ex_mem_out (ex_mem_out)
);

//--- rtl/ex_top.sv
/* execute stage top */

`timescale 1ns/10ps

module ex_top (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   stall,       // from memory stage
  input  ex_pkg::id_ex_packet_t  id_ex_in,    // from decode
  output ex_pkg::ex_mem_packet_t ex_mem_out
);

  ex_pkg::word_t opa;
  ex_pkg::word_t opb;
  ex_pkg::word_t alu_result;
  logic          cond;
  logic          bad_opb_sel;

  ex_operand_sel operand_sel_i (
    .id_ex_in    (id_ex_in),
    .opa         (opa),
    .opb         (opb),
    .bad_opb_sel (bad_opb_sel)
  );

  ex_alu alu_i (
    .opa    (opa),
    .opb    (opb),
    .func   (id_ex_in.alu_func),
    .result (alu_result)
  );

  // condition always tests register a
  ex_brcond brcond_i (
    .opa  (id_ex_in.rega_value),
    .func (id_ex_in.inst[28:26]),
    .cond (cond)
  );

  ex_result_merge result_merge_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .stall       (stall),
    .id_ex_in    (id_ex_in),
    .alu_result  (alu_result),
    .cond        (cond),
    .bad_opb_sel (bad_opb_sel),
    .ex_mem_out  (ex_mem_out)
  );

endmodule

//--- rtl/ex_result_merge.sv
/* ex/mem merge and register */

`timescale 1ns/10ps

`include "ex_cfg.svh"

module ex_result_merge (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   stall,        // downstream back-pressure
  input  ex_pkg::id_ex_packet_t  id_ex_in,
  input  ex_pkg::word_t          alu_result,
  input  logic                   cond,         // from the branch tester
  input  logic                   bad_opb_sel,
  output ex_pkg::ex_mem_packet_t ex_mem_out
);

  ex_pkg::ex_mem_packet_t ex_mem_next;  // packet formed this cycle
  logic                   take_branch;

  ////////////////////////////////
  // branch decision
  ////////////////////////////////

  // unconditional, or conditional with the test true
  assign take_branch = id_ex_in.valid &
                       (id_ex_in.uncond_branch | (id_ex_in.cond_branch & cond));

  ////////////////////////////////
  // next packet
  ////////////////////////////////

  always_comb begin
    ex_mem_next              = '0;
    ex_mem_next.alu_result   = alu_result;
    ex_mem_next.npc          = id_ex_in.npc;
    ex_mem_next.inst         = id_ex_in.inst;
    ex_mem_next.rega_value   = id_ex_in.rega_value;  // store data
    ex_mem_next.dest_reg_idx = id_ex_in.dest_reg_idx;
    ex_mem_next.take_branch  = take_branch;

    // bubbles may not touch memory
    ex_mem_next.rd_mem  = id_ex_in.rd_mem & id_ex_in.valid;
    ex_mem_next.wr_mem  = id_ex_in.wr_mem & id_ex_in.valid;

    ex_mem_next.halt    = id_ex_in.halt;
    ex_mem_next.illegal = id_ex_in.illegal | bad_opb_sel;  // decode or select fault
    ex_mem_next.valid   = id_ex_in.valid;
  end

  ////////////////////////////////
  // ex/mem register
  ////////////////////////////////

  // one stage of latency, frozen while stall is high
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem_out <= '0;          // all flags inactive
    end else if (!stall) begin
      ex_mem_out <= ex_mem_next;
    end
  end

endmodule

//--- rtl/ex_brcond.sv
/* branch condition */

`timescale 1ns/10ps

`include "ex_cfg.svh"

module ex_brcond (
  input  ex_pkg::word_t opa,   // register a value
  input  logic [2:0]    func,  // inst[28:26]
  output logic          cond
);

  logic is_zero;
  logic is_neg;
  logic raw;  // before the invert

  assign is_zero = (opa == '0);
  assign is_neg  = opa[`EX_WORD_W-1];

  // test select
  always_comb begin
    case (func[1:0])
      2'b00:   raw = ~opa[0];            // low bit clear
      2'b01:   raw = is_zero;            // eq
      2'b10:   raw = is_neg;             // lt
      default: raw = is_neg | is_zero;   // le
    endcase
  end

  assign cond = raw ^ func[2];  // upper bit gives the opposite test

endmodule

//--- rtl/ex_alu.sv
/* execute alu */

`timescale 1ns/10ps

`include "ex_cfg.svh"

module ex_alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_e func,
  output ex_pkg::word_t     result
);

  logic [`EX_SHAMT_W-1:0] shamt;  // low bits of opb only
  logic                   lt_s;   // signed less-than
  logic                   lt_u;   // unsigned less-than
  logic                   eq;

  // signed compare built from the unsigned one
  function automatic logic signed_lt(input ex_pkg::word_t a, input ex_pkg::word_t b);
    logic sa;
    logic sb;
    sa = a[`EX_WORD_W-1];
    sb = b[`EX_WORD_W-1];
    if (sa == sb) begin
      signed_lt = (a < b);  // same sign, magnitude order holds
    end else begin
      signed_lt = sa;       // negative one is smaller
    end
  endfunction

  assign shamt = opb[`EX_SHAMT_W-1:0];
  assign lt_u  = (opa < opb);
  assign lt_s  = signed_lt(opa, opb);
  assign eq    = (opa == opb);

  ////////////////////////////////
  // function decode
  ////////////////////////////////

  always_comb begin
    case (func)
      ex_pkg::ALU_ADDQ:   result = opa + opb;
      ex_pkg::ALU_SUBQ:   result = opa - opb;
      ex_pkg::ALU_AND:    result = opa & opb;
      ex_pkg::ALU_BIC:    result = opa & ~opb;
      ex_pkg::ALU_BIS:    result = opa | opb;
      ex_pkg::ALU_ORNOT:  result = opa | ~opb;
      ex_pkg::ALU_XOR:    result = opa ^ opb;
      ex_pkg::ALU_EQV:    result = opa ^ ~opb;
      ex_pkg::ALU_SRL:    result = opa >> shamt;
      ex_pkg::ALU_SLL:    result = opa << shamt;
      ex_pkg::ALU_SRA:    result = $signed(opa) >>> shamt;  // sign fill
      ex_pkg::ALU_MULQ:   result = opa * opb;               // truncated to 64
      // compares put the flag in bit 0
      ex_pkg::ALU_CMPULT: result = ex_pkg::word_t'(lt_u);
      ex_pkg::ALU_CMPEQ:  result = ex_pkg::word_t'(eq);
      ex_pkg::ALU_CMPULE: result = ex_pkg::word_t'(lt_u | eq);
      ex_pkg::ALU_CMPLT:  result = ex_pkg::word_t'(lt_s);
      ex_pkg::ALU_CMPLE:  result = ex_pkg::word_t'(lt_s | eq);
      default:            result = '0;  // unused codes
    endcase
  end

endmodule

//--- rtl/ex_operand_sel.sv
/* alu operand select */

`timescale 1ns/10ps

`include "ex_cfg.svh"

module ex_operand_sel (
  input  ex_pkg::id_ex_packet_t id_ex_in,
  output ex_pkg::word_t         opa,
  output ex_pkg::word_t         opb,
  output logic                  bad_opb_sel  // opb_select code 3
);

  ex_pkg::word_t mem_disp;  // memory format offset
  ex_pkg::word_t br_disp;   // branch format offset, in bytes
  ex_pkg::word_t alu_imm;   // operate format literal

  ////////////////////////////////
  // immediates
  ////////////////////////////////

  // 16-bit displacement, sign extended
  assign mem_disp = {{(`EX_WORD_W-16){id_ex_in.inst[15]}}, id_ex_in.inst[15:0]};

  // 21-bit word displacement, sign extended, times four
  assign br_disp = {{(`EX_WORD_W-23){id_ex_in.inst[20]}}, id_ex_in.inst[20:0], 2'b00};

  assign alu_imm = {{(`EX_WORD_W-8){1'b0}}, id_ex_in.inst[20:13]};  // zero extended

  ////////////////////////////////
  // operand muxes
  ////////////////////////////////

  always_comb begin
    case (id_ex_in.opa_select)
      ex_pkg::REGA:     opa = id_ex_in.rega_value;
      ex_pkg::MEM_DISP: opa = mem_disp;
      ex_pkg::NPC:      opa = id_ex_in.npc;
      default:          opa = ~ex_pkg::word_t'(3);  // NOT3
    endcase
  end

  // illegal select drives zero and raises the flag
  always_comb begin
    bad_opb_sel = 1'b0;
    case (id_ex_in.opb_select)
      ex_pkg::REGB:    opb = id_ex_in.regb_value;
      ex_pkg::ALU_IMM: opb = alu_imm;
      ex_pkg::BR_DISP: opb = br_disp;
      default: begin
        opb         = '0;
        bad_opb_sel = 1'b1;
      end
    endcase
  end

endmodule

//--- rtl/ex_pkg.sv
/* execute stage types */

`include "ex_cfg.svh"

package ex_pkg;

  ////////////////////////////////
  // width types
  ////////////////////////////////

  typedef logic [`EX_WORD_W-1:0]    word_t;     // data word, pc
  typedef logic [`EX_INST_W-1:0]    inst_t;     // raw instruction bits
  typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;  // destination register

  ////////////////////////////////
  // alu function codes
  ////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,  // add
    ALU_SUBQ   = 5'h01,  // subtract
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,  // and with complement
    ALU_BIS    = 5'h04,  // or
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,  // xnor
    ALU_SRL    = 5'h08,  // logical right
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,  // arithmetic right
    ALU_MULQ   = 5'h0b,  // low 64 bits of product
    ALU_CMPULT = 5'h0c,
    ALU_CMPEQ  = 5'h0d,
    ALU_CMPULE = 5'h0e,
    ALU_CMPLT  = 5'h0f,  // signed
    ALU_CMPLE  = 5'h10   // signed
  } alu_func_e;

  ////////////////////////////////
  // operand selects
  ////////////////////////////////

  // operand a source
  typedef enum logic [1:0] {
    REGA     = 2'h0,
    MEM_DISP = 2'h1,  // memory displacement
    NPC      = 2'h2,  // next pc, for link and branch target
    NOT3     = 2'h3   // ~3, alignment mask
  } opa_sel_e;

  // operand b source, code 3 is not a legal select
  typedef enum logic [1:0] {
    REGB    = 2'h0,
    ALU_IMM = 2'h1,  // 8-bit literal
    BR_DISP = 2'h2   // branch displacement
  } opb_sel_e;

  ////////////////////////////////
  // pipeline packets
  ////////////////////////////////

  // decode to execute
  typedef struct packed {
    word_t     npc;
    inst_t     inst;
    word_t     rega_value;
    word_t     regb_value;
    opa_sel_e  opa_select;
    opb_sel_e  opb_select;
    alu_func_e alu_func;
    reg_idx_t  dest_reg_idx;
    logic      rd_mem;
    logic      wr_mem;
    logic      cond_branch;
    logic      uncond_branch;
    logic      halt;
    logic      illegal;
    logic      valid;
  } id_ex_packet_t;

  // execute to memory
  typedef struct packed {
    word_t    alu_result;   // also the branch target
    word_t    npc;
    inst_t    inst;
    word_t    rega_value;   // store data
    reg_idx_t dest_reg_idx;
    logic     take_branch;
    logic     rd_mem;
    logic     wr_mem;
    logic     halt;
    logic     illegal;
    logic     valid;
  } ex_mem_packet_t;

endpackage

//--- rtl/ex_cfg.svh
/* execute stage widths */

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

////////////////////////////////
// datapath
////////////////////////////////

// one quadword through the alu and the pipeline registers
`define EX_WORD_W 64

// shift count, enough to reach bit 63
`define EX_SHAMT_W 6

////////////////////////////////
// instruction fields
////////////////////////////////

`define EX_REG_IDX_W 5  // 32 architectural registers

// fixed-length instruction word
`define EX_INST_W 32

`endif
